// File: bench/deque_tb_table.svh
// Directed commands for the deque testbench with their expected outcomes
// Rows run in order from the reset state, and each row's count is the state after it
// Included inside deque_tb after the deque_pkg import

// Kind of answer a command should get
typedef enum logic [1:0] {
  RSP_NONE = 2'd0,
  RSP_DATA = 2'd1,
  RSP_ERR  = 2'd2
} rsp_kind_e;

// One directed step
typedef struct packed {
  logic      clear;
  logic      valid;
  deque_op_e op;
  data_t     data;
  rsp_kind_e kind;
  data_t     exp_data;
  count_t    exp_count;
} row_t;

localparam int N_ROWS = 38;

// Columns: clear, valid, op, data, expected kind, expected data, expected count
row_t table_rows [N_ROWS] = '{
  // Pops on an empty deque are rejected
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_ERR,  16'h0000, 4'd0},
  '{1'b0, 1'b1, OP_POP_BACK,   16'h0000, RSP_ERR,  16'h0000, 4'd0},
  // Push back then pop front gives FIFO order
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'h1001, RSP_NONE, 16'h0000, 4'd1},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'h1002, RSP_NONE, 16'h0000, 4'd2},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'h1003, RSP_NONE, 16'h0000, 4'd3},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_DATA, 16'h1001, 4'd2},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_DATA, 16'h1002, 4'd1},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_DATA, 16'h1003, 4'd0},
  // Push front then pop front gives LIFO order
  '{1'b0, 1'b1, OP_PUSH_FRONT, 16'hA001, RSP_NONE, 16'h0000, 4'd1},
  '{1'b0, 1'b1, OP_PUSH_FRONT, 16'hA002, RSP_NONE, 16'h0000, 4'd2},
  '{1'b0, 1'b1, OP_PUSH_FRONT, 16'hA003, RSP_NONE, 16'h0000, 4'd3},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_DATA, 16'hA003, 4'd2},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_DATA, 16'hA002, 4'd1},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_DATA, 16'hA001, 4'd0},
  // Fill to twelve, the tail crosses the wrap on the way
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB000, RSP_NONE, 16'h0000, 4'd1},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB001, RSP_NONE, 16'h0000, 4'd2},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB002, RSP_NONE, 16'h0000, 4'd3},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB003, RSP_NONE, 16'h0000, 4'd4},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB004, RSP_NONE, 16'h0000, 4'd5},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB005, RSP_NONE, 16'h0000, 4'd6},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB006, RSP_NONE, 16'h0000, 4'd7},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB007, RSP_NONE, 16'h0000, 4'd8},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB008, RSP_NONE, 16'h0000, 4'd9},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB009, RSP_NONE, 16'h0000, 4'd10},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB00A, RSP_NONE, 16'h0000, 4'd11},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hB00B, RSP_NONE, 16'h0000, 4'd12},
  // Pushes on a full deque are rejected
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hE001, RSP_ERR,  16'h0000, 4'd12},
  '{1'b0, 1'b1, OP_PUSH_FRONT, 16'hE002, RSP_ERR,  16'h0000, 4'd12},
  '{1'b0, 1'b1, OP_POP_BACK,   16'h0000, RSP_DATA, 16'hB00B, 4'd11},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_DATA, 16'hB000, 4'd10},
  // Clear drops the push that comes with it
  '{1'b1, 1'b1, OP_PUSH_BACK,  16'hF001, RSP_NONE, 16'h0000, 4'd0},
  '{1'b0, 1'b1, OP_POP_FRONT,  16'h0000, RSP_ERR,  16'h0000, 4'd0},
  // Head steps from 0 down to 11 here
  '{1'b0, 1'b1, OP_PUSH_FRONT, 16'hC001, RSP_NONE, 16'h0000, 4'd1},
  '{1'b0, 1'b1, OP_POP_BACK,   16'h0000, RSP_DATA, 16'hC001, 4'd0},
  '{1'b0, 1'b1, OP_PUSH_BACK,  16'hD001, RSP_NONE, 16'h0000, 4'd1},
  '{1'b1, 1'b1, OP_POP_FRONT,  16'h0000, RSP_NONE, 16'h0000, 4'd0},
  '{1'b0, 1'b1, OP_POP_BACK,   16'h0000, RSP_ERR,  16'h0000, 4'd0},
  '{1'b1, 1'b0, OP_PUSH_BACK,  16'h0000, RSP_NONE, 16'h0000, 4'd0}
};

// File: bench/deque_tb.sv
// Testbench for the 12-entry deque, directed table first and then a random phase
// Each command is followed by two idle cycles and checked two edges after it is driven
// The random phase starts from an empty deque, as the table leaves it
`timescale 1ns/1ns

module deque_tb
  import deque_pkg::*;
;

  `include "deque_tb_table.svh"

  localparam int NUM_RANDOM    = 300;
  localparam int CYCLES_PER_OP = 3;
  localparam int RESET_CYCLES  = 16;
  // Whole run in ns with a margin of 100 cycles
  localparam int TIMEOUT_NS =
    ((N_ROWS + NUM_RANDOM) * CYCLES_PER_OP + RESET_CYCLES + 100) * 10;

  logic       clk;
  logic       arst_n;
  logic       clear;
  logic       cmd_valid;
  deque_cmd_t cmd;
  logic       rsp_valid;
  data_t      rsp_data;
  logic       err;
  count_t     count;
  logic       full;
  logic       empty;

  // Reference contents for the random phase, front of the deque at index 0
  data_t  ref_q[$];
  integer seed;

  deque_top dut_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .clear    (clear),
    .cmd_valid(cmd_valid),
    .cmd      (cmd),
    .rsp_valid(rsp_valid),
    .rsp_data (rsp_data),
    .err      (err),
    .count    (count),
    .full     (full),
    .empty    (empty)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  // Drives one command for a cycle, then idles and checks the answer
  task automatic apply_op(input logic clr, input logic vld, input deque_op_e op,
                          input data_t data, input rsp_kind_e kind, input data_t exp_data,
                          input count_t exp_count);
    @(posedge clk);
    clear     <= clr;
    cmd_valid <= vld;
    cmd       <= '{op: op, data: data};
    // The previous answer must have lasted a single cycle
    @(negedge clk);
    check_flag(rsp_valid, 1'b0, "rsp_valid after the previous answer");
    check_flag(err, 1'b0, "err after the previous answer");
    @(posedge clk);
    clear     <= 1'b0;
    cmd_valid <= 1'b0;
    // The command sits in the input stage here, so no strobe yet
    @(negedge clk);
    check_flag(rsp_valid, 1'b0, "rsp_valid before the answer");
    check_flag(err, 1'b0, "err before the answer");
    @(posedge clk);
    @(negedge clk);
    check_flag(rsp_valid, kind == RSP_DATA, "rsp_valid");
    check_flag(err, kind == RSP_ERR, "err");
    if (kind == RSP_DATA) begin
      check_data(rsp_data, exp_data, "rsp_data");
    end
    check_count(count, exp_count, "count");
    check_flag(full, exp_count == count_t'(DEPTH), "full");
    check_flag(empty, exp_count == '0, "empty");
  endtask

  // Random commands at both ends, expected answers come from ref_q
  task automatic run_random(input int n);
    integer    r;
    deque_op_e op;
    data_t     wdata;
    data_t     exp;
    rsp_kind_e kind;
    for (int i = 0; i < n; i++) begin
      r     = $random(seed);
      op    = deque_op_e'(r[1:0]);
      wdata = data_t'($random(seed));
      exp   = '0;
      kind  = RSP_ERR;
      case (op)
        OP_PUSH_FRONT: begin
          if (ref_q.size() < DEPTH) begin
            ref_q.push_front(wdata);
            kind = RSP_NONE;
          end
        end
        OP_PUSH_BACK: begin
          if (ref_q.size() < DEPTH) begin
            ref_q.push_back(wdata);
            kind = RSP_NONE;
          end
        end
        OP_POP_FRONT: begin
          if (ref_q.size() > 0) begin
            exp  = ref_q.pop_front();
            kind = RSP_DATA;
          end
        end
        default: begin
          if (ref_q.size() > 0) begin
            exp  = ref_q.pop_back();
            kind = RSP_DATA;
          end
        end
      endcase
      apply_op(1'b0, 1'b1, op, wdata, kind, exp, count_t'(ref_q.size()));
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    clear     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    seed      = 32'h5ae7_5db1;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    // Idle state straight after reset
    @(negedge clk);
    check_count(count, '0, "count after reset");
    check_flag(empty, 1'b1, "empty after reset");
    check_flag(full, 1'b0, "full after reset");
    check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
    check_flag(err, 1'b0, "err after reset");
    foreach (table_rows[i]) begin
      apply_op(table_rows[i].clear, table_rows[i].valid, table_rows[i].op,
               table_rows[i].data, table_rows[i].kind, table_rows[i].exp_data,
               table_rows[i].exp_count);
    end
    run_random(NUM_RANDOM);
    $display("Test OK");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    report_failure("Timeout: the commands did not all finish in the expected time");
  end

endmodule : deque_tb

// File: design/deque_ctrl.sv
// Deque controller with head, tail and occupancy counters
// Commands and clear are registered first, then applied on the next edge
// A command that meets clear in the same cycle is dropped without err
// Rejected commands change no state and raise err for one cycle
`timescale 1ns/1ns

module deque_ctrl
  import deque_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       clear,
  input  logic       cmd_valid,
  input  deque_cmd_t cmd,
  output logic       wr_en,
  output idx_t       wr_idx,
  output data_t      wr_data,
  output logic       rd_en,
  output idx_t       rd_idx,
  output logic       rsp_valid,
  output logic       err,
  output count_t     count,
  output logic       full,
  output logic       empty
);

  // Registered inputs
  logic       cmd_valid_q;
  logic       clear_q;
  deque_cmd_t cmd_q;

  // Decoded command
  logic       live;
  logic       push_front;
  logic       push_back;
  logic       pop_front;
  logic       pop_back;
  logic       accept_push;
  logic       accept_pop;
  logic       reject;

  // Counter controls and values
  logic       head_incr;
  logic       head_decr;
  logic       tail_incr;
  logic       tail_decr;
  idx_t       head;
  idx_t       head_next;
  idx_t       tail;
  idx_t       tail_next;

  // ------------------------------------------------------------
  // Input stage
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_valid_q <= 1'b0;
      clear_q     <= 1'b0;
    end else begin
      cmd_valid_q <= cmd_valid;
      clear_q     <= clear;
    end
  end

  // Payload only matters while cmd_valid_q is high
  always_ff @(posedge clk) begin
    cmd_q <= cmd;
  end

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------

  // Clear in the same cycle cancels the command
  assign live = cmd_valid_q & ~clear_q;

  assign push_front = live && (cmd_q.op == OP_PUSH_FRONT);
  assign push_back  = live && (cmd_q.op == OP_PUSH_BACK);
  assign pop_front  = live && (cmd_q.op == OP_POP_FRONT);
  assign pop_back   = live && (cmd_q.op == OP_POP_BACK);

  // Pushes need room and pops need an entry
  assign accept_push = (push_front | push_back) & ~full;
  assign accept_pop  = (pop_front | pop_back) & ~empty;
  assign reject      = live & ~accept_push & ~accept_pop;

  // Head moves down on push front and up on pop front
  assign head_decr = push_front & ~full;
  assign head_incr = pop_front & ~empty;

  // Tail moves up on push back and down on pop back
  assign tail_incr = push_back & ~full;
  assign tail_decr = pop_back & ~empty;

  // ------------------------------------------------------------
  // Counters
  // ------------------------------------------------------------

  updown_counter #(.MaxValue(IDX_MAX), .Wrap(1'b1)) head_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (clear_q),
    .incr      (head_incr),
    .decr      (head_decr),
    .value     (head),
    .value_next(head_next)
  );

  updown_counter #(.MaxValue(IDX_MAX), .Wrap(1'b1)) tail_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (clear_q),
    .incr      (tail_incr),
    .decr      (tail_decr),
    .value     (tail),
    .value_next(tail_next)
  );

  // Occupancy never leaves 0..DEPTH because full and empty gate the changes
  updown_counter #(.MaxValue(DEPTH), .Wrap(1'b0)) occ_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (clear_q),
    .incr      (accept_push),
    .decr      (accept_pop),
    .value     (count),
    .value_next()
  );

  assign full  = (count == count_t'(DEPTH));
  assign empty = (count == '0);

  // ------------------------------------------------------------
  // Storage addressing
  // ------------------------------------------------------------

  // Push front writes one below the head, push back writes at the tail
  assign wr_en   = accept_push;
  assign wr_idx  = push_front ? head_next : tail;
  assign wr_data = cmd_q.data;

  // Pop front reads the head, pop back reads one below the tail
  assign rd_en  = accept_pop;
  assign rd_idx = pop_back ? tail_next : head;

  // ------------------------------------------------------------
  // Response strobes
  // ------------------------------------------------------------

  // Registered so rsp_valid lines up with the registered read data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
      err       <= 1'b0;
    end else begin
      rsp_valid <= accept_pop;
      err       <= reject;
    end
  end

endmodule : deque_ctrl

// File: design/deque_pkg.sv
// Shared types and sizes for the 12-entry deque
// Depth is not a power of two, so index counters need explicit wrap logic
// Index and count types are both 4 bits wide

package deque_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // Number of storage entries
  localparam int DEPTH = 12;

  // Width of one stored word
  localparam int DATA_W = 16;

  // Index runs from 0 to DEPTH-1
  localparam int IDX_W = $clog2(DEPTH);
  localparam int IDX_MAX = DEPTH - 1;

  // Occupancy runs from 0 to DEPTH inclusive
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [CNT_W-1:0] count_t;

  // One operation per command, encoded on two bits
  typedef enum logic [1:0] {
    OP_PUSH_FRONT = 2'd0,
    OP_PUSH_BACK  = 2'd1,
    OP_POP_FRONT  = 2'd2,
    OP_POP_BACK   = 2'd3
  } deque_op_e;

  // Command word as it arrives from outside
  // The data field only matters for pushes
  typedef struct packed {
    deque_op_e op;
    data_t     data;
  } deque_cmd_t;

endpackage : deque_pkg

// File: design/deque_storage.sv
// Word array for the deque with one write port and one read port
// The array has no reset, so unread entries hold unknown data after power up
// Read data is registered and holds its value between reads
`timescale 1ns/1ns

module deque_storage
  import deque_pkg::*;
(
  input  logic  clk,
  input  logic  wr_en,
  input  idx_t  wr_idx,
  input  data_t wr_data,
  input  logic  rd_en,
  input  idx_t  rd_idx,
  output data_t rd_data
);

  // One word per deque entry
  data_t mem [DEPTH];

  // ------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------

  // The controller only issues indices below DEPTH
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------

  // Addressed word is captured on the same edge that samples rd_en
  // A write and a read never target the same cycle since commands are one at a time
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule : deque_storage

// File: design/deque_top.sv
// Top of the 12-entry deque
// One command per cycle with no back-pressure, and every command is answered
// Results appear two edges after the command is driven into the input stage
`timescale 1ns/1ns

module deque_top
  import deque_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       clear,
  input  logic       cmd_valid,
  input  deque_cmd_t cmd,
  output logic       rsp_valid,
  output data_t      rsp_data,
  output logic       err,
  output count_t     count,
  output logic       full,
  output logic       empty
);

  // Storage port wires
  logic  wr_en;
  idx_t  wr_idx;
  data_t wr_data;
  logic  rd_en;
  idx_t  rd_idx;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  deque_ctrl ctrl_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .clear    (clear),
    .cmd_valid(cmd_valid),
    .cmd      (cmd),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_idx   (rd_idx),
    .rsp_valid(rsp_valid),
    .err      (err),
    .count    (count),
    .full     (full),
    .empty    (empty)
  );

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // Read data is valid in the cycle where rsp_valid is high
  deque_storage storage_i (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_idx (wr_idx),
    .wr_data(wr_data),
    .rd_en  (rd_en),
    .rd_idx (rd_idx),
    .rd_data(rsp_data)
  );

endmodule : deque_top

// File: design/updown_counter.sv
// Up/down counter that changes by at most one per cycle
// With Wrap set it wraps between 0 and MaxValue even if MaxValue+1 is not 2**n
// Without Wrap the caller must keep the value in range
// Clear wins over any change in the same cycle
`timescale 1ns/1ns

module updown_counter #(
  parameter int unsigned MaxValue = 1,
  parameter bit Wrap = 1,
  localparam int ValueW = $clog2(MaxValue + 1)
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              clear,
  input  logic              incr,
  input  logic              decr,
  output logic [ValueW-1:0] value,
  output logic [ValueW-1:0] value_next
);

  // One extra bit catches the step past MaxValue or below zero
  localparam int TempW = ValueW + 1;
  localparam int unsigned MaxValueP1 = MaxValue + 1;
  localparam bit IsPow2 = (MaxValueP1 & MaxValue) == 0;

  logic [TempW-1:0] value_temp;
  logic [TempW-1:0] value_fixed;
  logic             load_en;

  // ------------------------------------------------------------
  // Next value
  // ------------------------------------------------------------

  // Raw sum, may land outside 0..MaxValue for one step
  assign value_temp = {1'b0, value} + TempW'(incr) - TempW'(decr);

  if (Wrap && !IsPow2) begin : gen_wrap_fix
    logic [TempW-1:0] max_p1;
    logic             net_decr;
    logic             out_of_range;

    assign max_p1 = TempW'(MaxValueP1);

    // A net decrement can only leave the range by going below zero
    assign net_decr = decr & ~incr;

    // Below zero shows up as a large value in the wider sum
    assign out_of_range = value_temp > TempW'(MaxValue);

    // Move back into range by the distance MaxValue+1
    always_comb begin
      if (!out_of_range) begin
        value_fixed = value_temp;
      end else if (net_decr) begin
        value_fixed = value_temp + max_p1;
      end else begin
        value_fixed = value_temp - max_p1;
      end
    end
  end else begin : gen_no_fix
    // Power of two range wraps by truncation, no wrap means no correction
    assign value_fixed = value_temp;
  end

  assign value_next = clear ? '0 : value_fixed[ValueW-1:0];

  // ------------------------------------------------------------
  // State
  // ------------------------------------------------------------

  // Load only when something changes
  assign load_en = clear | incr | decr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= '0;
    end else if (load_en) begin
      value <= value_next;
    end
  end

endmodule : updown_counter

// File: run.sh
#!/bin/sh
# Build and run the deque testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module deque_tb -o deque_sim

out=$(./obj_dir/deque_sim || true)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

// File: sim.f
+incdir+bench
design/deque_pkg.sv
design/updown_counter.sv
design/deque_storage.sv
design/deque_ctrl.sv
design/deque_top.sv
bench/deque_tb.sv
